//--- common/addr_map_pkg.sv
//**********************************************************************
// address map definitions for the core address front end
// EVA field layouts, local region and CSR encodings, fixed widths
//**********************************************************************

package addr_map_pkg;

  // core datapath and EVA width
  localparam int data_width_gp = 32;

  // endpoint word address widths carried in the EVA
  localparam int global_epa_width_gp = 18;
  localparam int tile_group_epa_width_gp = 16;

  // local data memory word address
  localparam int dmem_addr_width_gp = 10;

  // remote tags in the upper EVA bits
  localparam logic [1:0] global_remote_tag_gp = 2'b01;
  localparam logic [2:0] tile_group_remote_tag_gp = 3'b001;

  // page select in bits 23..16 of local space
  localparam logic [7:0] local_dmem_page_gp = 8'h00;
  localparam logic [7:0] local_csr_page_gp = 8'h10;

  // global EVA, coordinates and word address taken as-is
  typedef struct packed {
    logic [1:0] remote;
    logic [3:0] y_cord;
    logic [5:0] x_cord;
    logic [global_epa_width_gp-1:0] addr;
    logic [1:0] byte_offset;
  } eva_global_s;

  // tile-group EVA, coordinates relative to the origin
  typedef struct packed {
    logic [2:0] remote;
    logic [4:0] y_cord;
    logic [5:0] x_cord;
    logic [tile_group_epa_width_gp-1:0] addr;
    logic [1:0] byte_offset;
  } eva_tile_group_s;

  // local EVA, top byte zero
  // csr index sits in the two low word address bits
  typedef struct packed {
    logic [7:0] remote;
    logic [7:0] page;
    logic [3:0] unused;
    logic [dmem_addr_width_gp-1:0] word_addr;
    logic [1:0] byte_offset;
  } eva_local_s;

  typedef enum logic [1:0] {
    region_none,
    region_dmem,
    region_csr
  } local_region_e;

  typedef enum logic [1:0] {
    csr_tgo_x = 2'd0,
    csr_tgo_y = 2'd1,
    csr_dram_enable = 2'd2
  } csr_index_e;

endpackage

//--- common/net_pkg.sv
//**********************************************************************
// network side definitions
// request opcodes, NPA grouping and the outgoing request packet
//**********************************************************************

package net_pkg;

  // global mesh coordinates
  localparam int x_cord_width_gp = 6;
  localparam int y_cord_width_gp = 4;

  // pod part of the coordinates, upper bits
  localparam int pod_x_width_gp = 3;
  localparam int pod_y_width_gp = 2;

  // endpoint physical address, in words
  localparam int epa_width_gp = 28;

  typedef enum logic {
    op_load = 1'b0,
    op_store = 1'b1
  } req_op_e;

  // network physical address
  typedef struct packed {
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0] epa;
  } npa_s;

  // request packet toward the mesh
  // data follows the 32 bit core word
  typedef struct packed {
    req_op_e op;
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0] epa;
    logic [31:0] data;
  } net_req_s;

endpackage

//--- eva_to_npa/eva_to_npa.sv
//**********************************************************************
// EVA to NPA translation for remote space
// maps DRAM, global and tile-group EVAs to x/y coordinates plus EPA
//**********************************************************************

`timescale 1ns/1ns

module eva_to_npa
  import addr_map_pkg::*;
  import net_pkg::*;
  #(parameter int num_tiles_x_p = 8,
    parameter int num_tiles_y_p = 4,
    parameter int num_vcache_rows_p = 1,
    parameter int vcache_block_size_in_words_p = 8,
    parameter int vcache_size_p = 1024,
    localparam int x_subcord_width_lp = (num_tiles_x_p > 1) ? $clog2(num_tiles_x_p) : 1,
    localparam int y_subcord_width_lp = (num_tiles_y_p > 1) ? $clog2(num_tiles_y_p) : 1
  ) (
    // byte address from the core
    input  logic [data_width_gp-1:0]      eva_i,
    // tile-group origin
    input  logic [x_subcord_width_lp-1:0] tgo_x_i,
    input  logic [y_subcord_width_lp-1:0] tgo_y_i,
    input  logic [pod_x_width_gp-1:0]     pod_x_i,
    input  logic [pod_y_width_gp-1:0]     pod_y_i,
    // striped DRAM when set, plain block memory otherwise
    input  logic                          dram_enable_i,
    output npa_s                          npa_o,
    output logic                          is_invalid_addr_o
  );

  // word offset inside a cache line
  localparam int word_offset_width_lp =
    (vcache_block_size_in_words_p > 1) ? $clog2(vcache_block_size_in_words_p) : 1;
  // word offset inside a whole vcache
  localparam int lg_vcache_size_lp = (vcache_size_p > 1) ? $clog2(vcache_size_p) : 1;
  // vcache rows north and south of the pod
  localparam int row_id_width_lp = $clog2(2 * num_vcache_rows_p);
  localparam int dram_index_width_lp =
    data_width_gp - 1 - 2 - word_offset_width_lp - x_subcord_width_lp - row_id_width_lp;

  // bit positions, striped mode
  localparam int dram_x_lsb_lp = 2 + word_offset_width_lp;
  localparam int dram_row_lsb_lp = dram_x_lsb_lp + x_subcord_width_lp;
  localparam int dram_index_lsb_lp = dram_row_lsb_lp + row_id_width_lp;
  // bit positions, block memory mode
  localparam int blk_x_lsb_lp = 2 + lg_vcache_size_lp;
  localparam int blk_row_lsb_lp = blk_x_lsb_lp + x_subcord_width_lp;

  eva_global_s global_addr;
  eva_tile_group_s tile_group_addr;
  assign global_addr = eva_i;
  assign tile_group_addr = eva_i;

  logic is_dram_addr;
  logic is_global_addr;
  logic is_tile_group_addr;
  assign is_dram_addr = eva_i[data_width_gp-1];
  assign is_global_addr = (global_addr.remote == global_remote_tag_gp);
  assign is_tile_group_addr = (tile_group_addr.remote == tile_group_remote_tag_gp);

  // row id and x subcoord, picked by mode
  logic [row_id_width_lp-1:0] row_id;
  logic [x_subcord_width_lp-1:0] vc_x_subcord;
  logic [y_subcord_width_lp-1:0] vc_y_subcord;
  logic [pod_y_width_gp-1:0] vc_pod_y;
  logic [epa_width_gp-1:0] vc_epa;

  always_comb begin
    if (dram_enable_i) begin
      // line-granular striping
      row_id = eva_i[dram_row_lsb_lp +: row_id_width_lp];
      vc_x_subcord = eva_i[dram_x_lsb_lp +: x_subcord_width_lp];
      vc_epa = epa_width_gp'({eva_i[dram_index_lsb_lp +: dram_index_width_lp],
                              eva_i[2 +: word_offset_width_lp]});
    end else begin
      // whole vcache as one block, no striping
      row_id = eva_i[blk_row_lsb_lp +: row_id_width_lp];
      vc_x_subcord = eva_i[blk_x_lsb_lp +: x_subcord_width_lp];
      vc_epa = epa_width_gp'(eva_i[2 +: lg_vcache_size_lp]);
    end
  end

  // odd row id goes south into the next pod, even goes north
  assign vc_pod_y = row_id[0] ? pod_y_width_gp'(pod_y_i + 1'b1)
                              : pod_y_width_gp'(pod_y_i - 1'b1);

  // north rows count down from the edge, south rows count up
  // upper bits fill with the side, lower bits hold the layer
  always_comb begin
    vc_y_subcord = {y_subcord_width_lp{~row_id[0]}};
    for (int i = 0; i < row_id_width_lp - 1; i++) begin
      vc_y_subcord[i] = row_id[i+1] ^ ~row_id[0];
    end
  end

  // translation table, DRAM first
  always_comb begin
    is_invalid_addr_o = 1'b0;
    npa_o = '0;
    if (is_dram_addr) begin
      npa_o.x_cord = x_cord_width_gp'({pod_x_i, vc_x_subcord});
      npa_o.y_cord = y_cord_width_gp'({vc_pod_y, vc_y_subcord});
      npa_o.epa = vc_epa;
    end else if (is_global_addr) begin
      // coordinates straight from the EVA
      npa_o.x_cord = x_cord_width_gp'(global_addr.x_cord);
      npa_o.y_cord = y_cord_width_gp'(global_addr.y_cord);
      npa_o.epa = epa_width_gp'(global_addr.addr);
    end else if (is_tile_group_addr) begin
      // offset from origin, wraps inside the pod
      npa_o.x_cord = x_cord_width_gp'({pod_x_i,
        x_subcord_width_lp'(tile_group_addr.x_cord + tgo_x_i)});
      npa_o.y_cord = y_cord_width_gp'({pod_y_i,
        y_subcord_width_lp'(tile_group_addr.y_cord + tgo_y_i)});
      npa_o.epa = epa_width_gp'(tile_group_addr.addr);
    end else begin
      // no remote mapping
      is_invalid_addr_o = 1'b1;
    end
  end

endmodule

//--- source/local_addr_decode.sv
//**********************************************************************
// local address decode
// splits local space into dmem and CSR, holds the tile control registers
//**********************************************************************

`timescale 1ns/1ns

module local_addr_decode
  import addr_map_pkg::*;
  import net_pkg::*;
  #(parameter int num_tiles_x_p = 8,
    parameter int num_tiles_y_p = 4,
    localparam int x_subcord_width_lp = (num_tiles_x_p > 1) ? $clog2(num_tiles_x_p) : 1,
    localparam int y_subcord_width_lp = (num_tiles_y_p > 1) ? $clog2(num_tiles_y_p) : 1
  ) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_v_i,
    input  req_op_e                       req_op_i,
    input  logic [data_width_gp-1:0]      eva_i,
    input  logic [data_width_gp-1:0]      data_i,
    output local_region_e                 region_o,
    output logic [data_width_gp-1:0]      csr_rdata_o,
    output logic [x_subcord_width_lp-1:0] tgo_x_o,
    output logic [y_subcord_width_lp-1:0] tgo_y_o,
    output logic                          dram_enable_o
  );

  eva_local_s local_addr;
  assign local_addr = eva_i;

  // register index from word address bits
  csr_index_e csr_index;
  assign csr_index = csr_index_e'(local_addr.word_addr[1:0]);

  // top byte zero means own tile
  always_comb begin
    region_o = region_none;
    if (local_addr.remote == '0) begin
      if (local_addr.page == local_dmem_page_gp) begin
        region_o = region_dmem;
      end else if (local_addr.page == local_csr_page_gp) begin
        region_o = region_csr;
      end
    end
  end

  logic csr_we;
  assign csr_we = req_v_i && (region_o == region_csr) && (req_op_i == op_store);

  // control registers, written at the request edge
  // dram mode comes up enabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgo_x_o <= '0;
      tgo_y_o <= '0;
      dram_enable_o <= 1'b1;
    end else if (csr_we) begin
      case (csr_index)
        csr_tgo_x: tgo_x_o <= data_i[x_subcord_width_lp-1:0];
        csr_tgo_y: tgo_y_o <= data_i[y_subcord_width_lp-1:0];
        csr_dram_enable: dram_enable_o <= data_i[0];
        // index 3 has no register
        default: ;
      endcase
    end
  end

  // read side, current value zero-extended
  always_comb begin
    case (csr_index)
      csr_tgo_x: csr_rdata_o = data_width_gp'(tgo_x_o);
      csr_tgo_y: csr_rdata_o = data_width_gp'(tgo_y_o);
      csr_dram_enable: csr_rdata_o = data_width_gp'(dram_enable_o);
      default: csr_rdata_o = '0;
    endcase
  end

endmodule

//--- source/mem_req_dispatch.sv
//**********************************************************************
// request dispatcher
// picks one of dmem, CSR response, network or error and registers it
//**********************************************************************

`timescale 1ns/1ns

module mem_req_dispatch
  import addr_map_pkg::*;
  import net_pkg::*;
  (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_v_i,
    input  req_op_e                       req_op_i,
    input  logic [data_width_gp-1:0]      eva_i,
    input  logic [data_width_gp-1:0]      data_i,
    input  local_region_e                 region_i,
    input  logic [data_width_gp-1:0]      csr_rdata_i,
    input  npa_s                          npa_i,
    input  logic                          is_invalid_addr_i,
    // local memory side
    output logic                          dmem_v_o,
    output req_op_e                       dmem_op_o,
    output logic [dmem_addr_width_gp-1:0] dmem_addr_o,
    output logic [data_width_gp-1:0]      dmem_data_o,
    // register load response
    output logic                          csr_resp_v_o,
    output logic [data_width_gp-1:0]      csr_resp_data_o,
    // mesh side
    output logic                          net_v_o,
    output net_req_s                      net_req_o,
    output logic                          addr_err_v_o
  );

  eva_local_s local_addr;
  assign local_addr = eva_i;

  logic issue_dmem;
  logic issue_csr;
  logic issue_net;
  logic issue_err;

  // local space wins over remote verdict
  // csr store writes in the decoder and issues nothing here
  always_comb begin
    issue_dmem = 1'b0;
    issue_csr = 1'b0;
    issue_net = 1'b0;
    issue_err = 1'b0;
    if (req_v_i) begin
      case (region_i)
        region_dmem: issue_dmem = 1'b1;
        region_csr: issue_csr = (req_op_i == op_load);
        default: begin
          issue_err = is_invalid_addr_i;
          issue_net = !is_invalid_addr_i;
        end
      endcase
    end
  end

  // one-cycle valid pulses
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dmem_v_o <= 1'b0;
      csr_resp_v_o <= 1'b0;
      net_v_o <= 1'b0;
      addr_err_v_o <= 1'b0;
    end else begin
      dmem_v_o <= issue_dmem;
      csr_resp_v_o <= issue_csr;
      net_v_o <= issue_net;
      addr_err_v_o <= issue_err;
    end
  end

  // payload, loaded only for the chosen output
  always_ff @(posedge clk_i) begin
    if (issue_dmem) begin
      dmem_op_o <= req_op_i;
      dmem_addr_o <= local_addr.word_addr;
      dmem_data_o <= data_i;
    end
    if (issue_csr) begin
      csr_resp_data_o <= csr_rdata_i;
    end
    if (issue_net) begin
      net_req_o.op <= req_op_i;
      net_req_o.x_cord <= npa_i.x_cord;
      net_req_o.y_cord <= npa_i.y_cord;
      net_req_o.epa <= npa_i.epa;
      net_req_o.data <= data_i;
    end
  end

endmodule

//--- source/core_addr_xlate.sv
//**********************************************************************
// core address translation front end of one tile
// local decode and remote mapping side by side, one dispatch stage
//**********************************************************************

`timescale 1ns/1ns

module core_addr_xlate
  import addr_map_pkg::*;
  import net_pkg::*;
  #(parameter int num_tiles_x_p = 8,
    parameter int num_tiles_y_p = 4,
    parameter int num_vcache_rows_p = 1,
    parameter int vcache_block_size_in_words_p = 8,
    parameter int vcache_size_p = 1024,
    localparam int x_subcord_width_lp = (num_tiles_x_p > 1) ? $clog2(num_tiles_x_p) : 1,
    localparam int y_subcord_width_lp = (num_tiles_y_p > 1) ? $clog2(num_tiles_y_p) : 1
  ) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_v_i,
    input  req_op_e                       req_op_i,
    input  logic [data_width_gp-1:0]      req_eva_i,
    input  logic [data_width_gp-1:0]      req_data_i,
    // pod of this tile
    input  logic [pod_x_width_gp-1:0]     pod_x_i,
    input  logic [pod_y_width_gp-1:0]     pod_y_i,
    output logic                          dmem_v_o,
    output req_op_e                       dmem_op_o,
    output logic [dmem_addr_width_gp-1:0] dmem_addr_o,
    output logic [data_width_gp-1:0]      dmem_data_o,
    output logic                          csr_resp_v_o,
    output logic [data_width_gp-1:0]      csr_resp_data_o,
    output logic                          net_v_o,
    output net_req_s                      net_req_o,
    output logic                          addr_err_v_o
  );

  local_region_e region;
  logic [data_width_gp-1:0] csr_rdata;
  logic [x_subcord_width_lp-1:0] tgo_x;
  logic [y_subcord_width_lp-1:0] tgo_y;
  logic dram_enable;
  npa_s npa;
  logic is_invalid_addr;

  // own space and control registers
  local_addr_decode #(
    .num_tiles_x_p(num_tiles_x_p),
    .num_tiles_y_p(num_tiles_y_p)
  ) local_decode (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .req_v_i(req_v_i),
    .req_op_i(req_op_i),
    .eva_i(req_eva_i),
    .data_i(req_data_i),
    .region_o(region),
    .csr_rdata_o(csr_rdata),
    .tgo_x_o(tgo_x),
    .tgo_y_o(tgo_y),
    .dram_enable_o(dram_enable)
  );

  // remote mapping on the same EVA
  eva_to_npa #(
    .num_tiles_x_p(num_tiles_x_p),
    .num_tiles_y_p(num_tiles_y_p),
    .num_vcache_rows_p(num_vcache_rows_p),
    .vcache_block_size_in_words_p(vcache_block_size_in_words_p),
    .vcache_size_p(vcache_size_p)
  ) xlate (
    .eva_i(req_eva_i),
    .tgo_x_i(tgo_x),
    .tgo_y_i(tgo_y),
    .pod_x_i(pod_x_i),
    .pod_y_i(pod_y_i),
    .dram_enable_i(dram_enable),
    .npa_o(npa),
    .is_invalid_addr_o(is_invalid_addr)
  );

  mem_req_dispatch dispatch (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .req_v_i(req_v_i),
    .req_op_i(req_op_i),
    .eva_i(req_eva_i),
    .data_i(req_data_i),
    .region_i(region),
    .csr_rdata_i(csr_rdata),
    .npa_i(npa),
    .is_invalid_addr_i(is_invalid_addr),
    .dmem_v_o(dmem_v_o),
    .dmem_op_o(dmem_op_o),
    .dmem_addr_o(dmem_addr_o),
    .dmem_data_o(dmem_data_o),
    .csr_resp_v_o(csr_resp_v_o),
    .csr_resp_data_o(csr_resp_data_o),
    .net_v_o(net_v_o),
    .net_req_o(net_req_o),
    .addr_err_v_o(addr_err_v_o)
  );

endmodule

//--- sim/clk_gen.sv
//**********************************************************************
// testbench clock and reset source
// 20 ns clock, active low reset held for four cycles
//**********************************************************************

`timescale 1ns/1ns

module clk_gen #(
  parameter int half_period_p = 10,
  parameter int reset_cycles_p = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

  // release lands on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    #(2 * half_period_p * reset_cycles_p);
    rst_n_o = 1'b1;
  end

endmodule

//--- sim/tb_core_addr_xlate.sv
//**********************************************************************
// testbench for the core address translation front end
// random requests from a fixed seed, checked against a behavioural model
//**********************************************************************

`timescale 1ns/1ns

module tb_core_addr_xlate
  import addr_map_pkg::*;
  import net_pkg::*;
  ();

  localparam int random_steps_lp = 2000;
  localparam int reset_timeout_lp = 20;

  // the one output a request should raise
  typedef enum logic [2:0] {
    pulse_none,
    pulse_dmem,
    pulse_csr,
    pulse_net,
    pulse_err
  } pulse_e;

  // expected response of one request
  typedef struct packed {
    pulse_e kind;
    req_op_e op;
    logic [dmem_addr_width_gp-1:0] dmem_addr;
    logic [data_width_gp-1:0] data;
    net_req_s net;
  } outcome_s;

  logic clk;
  logic rst_n;
  logic req_v;
  req_op_e req_op;
  logic [31:0] req_eva;
  logic [31:0] req_data;
  logic [pod_x_width_gp-1:0] pod_x;
  logic [pod_y_width_gp-1:0] pod_y;
  logic dmem_v;
  req_op_e dmem_op;
  logic [dmem_addr_width_gp-1:0] dmem_addr;
  logic [31:0] dmem_data;
  logic csr_resp_v;
  logic [31:0] csr_resp_data;
  logic net_v;
  net_req_s net_req;
  logic addr_err_v;

  // model copy of the tile control registers
  logic [2:0] model_tgo_x;
  logic [1:0] model_tgo_y;
  logic model_dram_enable;

  integer seed;
  int value_errors;
  int other_errors;
  outcome_s outcome_pend;
  outcome_s outcome_now;

  clk_gen clock (
    .clk_o(clk),
    .rst_n_o(rst_n)
  );

  core_addr_xlate UUT (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .req_v_i(req_v),
    .req_op_i(req_op),
    .req_eva_i(req_eva),
    .req_data_i(req_data),
    .pod_x_i(pod_x),
    .pod_y_i(pod_y),
    .dmem_v_o(dmem_v),
    .dmem_op_o(dmem_op),
    .dmem_addr_o(dmem_addr),
    .dmem_data_o(dmem_data),
    .csr_resp_v_o(csr_resp_v),
    .csr_resp_data_o(csr_resp_data),
    .net_v_o(net_v),
    .net_req_o(net_req),
    .addr_err_v_o(addr_err_v)
  );

  // dmem, CSR, DRAM and tile-group get 3 of 16 draws each
  // global and the two unmapped kinds share the rest
  function automatic logic [31:0] random_eva();
    logic [31:0] r;
    logic [31:0] eva;
    int sel;
    r = $random(seed);
    sel = {$random(seed)} % 16;
    if (sel < 3) eva = {16'h0000, r[15:0]};
    else if (sel < 6) eva = {16'h0010, r[15:0]};
    else if (sel < 9) eva = {1'b1, r[30:0]};
    else if (sel < 11) eva = {2'b01, r[29:0]};
    else if (sel < 14) eva = {3'b001, r[28:0]};
    // local space, page neither dmem nor CSR
    else if (sel < 15) eva = {8'h00, r[23:16] | 8'h20, r[15:0]};
    else eva = {3'b000, r[28:24] | 5'h01, r[23:0]};
    return eva;
  endfunction

  function automatic outcome_s predict_outcome(input req_op_e op, input logic [31:0] eva,
                                               input logic [31:0] data);
    outcome_s e;
    logic row;
    logic [2:0] x_sub;
    logic [1:0] y_sub;
    e = '0;
    e.op = op;
    e.data = data;
    e.net.op = op;
    e.net.data = data;
    if (eva[31:16] == 16'h0000) begin
      e.kind = pulse_dmem;
      e.dmem_addr = eva[11:2];
    end else if (eva[31:16] == 16'h0010) begin
      // a store only writes the register
      e.kind = (op == op_load) ? pulse_csr : pulse_none;
      case (eva[3:2])
        2'd0: e.data = {29'd0, model_tgo_x};
        2'd1: e.data = {30'd0, model_tgo_y};
        2'd2: e.data = {31'd0, model_dram_enable};
        default: e.data = '0;
      endcase
    end else if (eva[31]) begin
      e.kind = pulse_net;
      if (model_dram_enable) begin
        // 8 word lines, x from the next three bits, row bit above
        row = eva[8];
        x_sub = eva[7:5];
        e.net.epa = {3'd0, eva[30:9], eva[4:2]};
      end else begin
        // each vcache holds 1024 contiguous words
        row = eva[15];
        x_sub = eva[14:12];
        e.net.epa = {18'd0, eva[11:2]};
      end
      e.net.x_cord = {pod_x, x_sub};
      // row 1 is the top row of the pod below, row 0 the bottom row above
      e.net.y_cord = row ? {pod_y + 2'd1, 2'b00} : {pod_y - 2'd1, 2'b11};
    end else if (eva[31:30] == 2'b01) begin
      e.kind = pulse_net;
      e.net.x_cord = eva[25:20];
      e.net.y_cord = eva[29:26];
      e.net.epa = {10'd0, eva[19:2]};
    end else if (eva[31:29] == 3'b001) begin
      e.kind = pulse_net;
      // offset from origin wraps inside the pod
      x_sub = eva[20:18] + model_tgo_x;
      y_sub = eva[25:24] + model_tgo_y;
      e.net.x_cord = {pod_x, x_sub};
      e.net.y_cord = {pod_y, y_sub};
      e.net.epa = {12'd0, eva[17:2]};
    end else begin
      e.kind = pulse_err;
    end
    return e;
  endfunction

  task automatic apply_csr_store(input logic [31:0] eva, input logic [31:0] data);
    if (eva[31:16] == 16'h0010) begin
      case (eva[3:2])
        2'd0: model_tgo_x = data[2:0];
        2'd1: model_tgo_y = data[1:0];
        2'd2: model_dram_enable = data[0];
        default: ;
      endcase
    end
  endtask

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    value_errors++;
    $display("[FAIL] at %0t ns %s expected 0x%h actual 0x%h", $time, name, expected, actual);
  endtask

  task automatic check_outputs(input outcome_s e);
    if (dmem_v !== (e.kind == pulse_dmem))
      report_value("dmem_v_o", 32'(e.kind == pulse_dmem), 32'(dmem_v));
    if (csr_resp_v !== (e.kind == pulse_csr))
      report_value("csr_resp_v_o", 32'(e.kind == pulse_csr), 32'(csr_resp_v));
    if (net_v !== (e.kind == pulse_net))
      report_value("net_v_o", 32'(e.kind == pulse_net), 32'(net_v));
    if (addr_err_v !== (e.kind == pulse_err))
      report_value("addr_err_v_o", 32'(e.kind == pulse_err), 32'(addr_err_v));
    // payload only where its valid fired
    if (e.kind == pulse_dmem && dmem_v) begin
      if (dmem_op !== e.op)
        report_value("dmem_op_o", 32'(e.op), 32'(dmem_op));
      if (dmem_addr !== e.dmem_addr)
        report_value("dmem_addr_o", 32'(e.dmem_addr), 32'(dmem_addr));
      if (dmem_data !== e.data)
        report_value("dmem_data_o", e.data, dmem_data);
    end
    if (e.kind == pulse_csr && csr_resp_v) begin
      if (csr_resp_data !== e.data)
        report_value("csr_resp_data_o", e.data, csr_resp_data);
    end
    if (e.kind == pulse_net && net_v) begin
      if (net_req.op !== e.net.op)
        report_value("net_req_o.op", 32'(e.net.op), 32'(net_req.op));
      if (net_req.x_cord !== e.net.x_cord)
        report_value("net_req_o.x_cord", 32'(e.net.x_cord), 32'(net_req.x_cord));
      if (net_req.y_cord !== e.net.y_cord)
        report_value("net_req_o.y_cord", 32'(e.net.y_cord), 32'(net_req.y_cord));
      if (net_req.epa !== e.net.epa)
        report_value("net_req_o.epa", 32'(e.net.epa), 32'(net_req.epa));
      if (net_req.data !== e.net.data)
        report_value("net_req_o.data", e.net.data, net_req.data);
    end
  endtask

  // one clock of stimulus, then check the request sampled at this edge
  task automatic drive_cycle(input logic v, input req_op_e op, input logic [31:0] eva,
                             input logic [31:0] data);
    @(posedge clk);
    outcome_now = outcome_pend;
    outcome_pend = '0;
    if (v) begin
      outcome_pend = predict_outcome(op, eva, data);
      // register write lands at the edge that samples the store
      if (op == op_store) apply_csr_store(eva, data);
    end
    req_v <= v;
    req_op <= op;
    req_eva <= eva;
    req_data <= data;
    @(negedge clk);
    check_outputs(outcome_now);
  endtask

  initial begin
    int wait_cycles;
    logic v;
    req_op_e op;
    logic [31:0] eva;
    logic [31:0] data;
    seed = 32'hc12d_f655;
    value_errors = 0;
    other_errors = 0;
    model_tgo_x = '0;
    model_tgo_y = '0;
    model_dram_enable = 1'b1;
    outcome_pend = '0;
    outcome_now = '0;
    req_v = 1'b0;
    req_op = op_load;
    req_eva = '0;
    req_data = '0;
    // tile placement stays fixed for the run
    pod_x = 3'($random(seed));
    pod_y = 2'($random(seed));

    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < reset_timeout_lp) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
      other_errors++;
      $display("reset was still asserted after %0d cycles", reset_timeout_lp);
    end else begin
      // idle after reset, nothing may pulse
      repeat (3) drive_cycle(1'b0, op_load, '0, '0);
      // register values out of reset
      drive_cycle(1'b1, op_load, 32'h0010_0000, '0);
      drive_cycle(1'b1, op_load, 32'h0010_0004, '0);
      drive_cycle(1'b1, op_load, 32'h0010_0008, '0);
      for (int i = 0; i < random_steps_lp; i++) begin
        v = ({$random(seed)} % 10) < 7;
        op = ($random(seed) & 1) ? op_store : op_load;
        eva = random_eva();
        data = $random(seed);
        drive_cycle(v, op, eva, data);
      end
      // drain the output stage
      repeat (2) drive_cycle(1'b0, op_load, '0, '0);
    end

    $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
common/addr_map_pkg.sv
common/net_pkg.sv
eva_to_npa/eva_to_npa.sv
source/local_addr_decode.sv
source/mem_req_dispatch.sv
source/core_addr_xlate.sv
sim/clk_gen.sv
sim/tb_core_addr_xlate.sv

//--- Makefile
# Verilator build and run for core_addr_xlate

SRCS := $(shell cat build.f)

.PHONY: run clean

run: obj_dir/Vtb_core_addr_xlate
	@out="$$(./obj_dir/Vtb_core_addr_xlate)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

obj_dir/Vtb_core_addr_xlate: build.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ns -f build.f \
	  --top-module tb_core_addr_xlate -Mdir obj_dir

clean:
	rm -rf obj_dir
